// File: hdl/bootmem_params.svh
`ifndef BOOTMEM_PARAMS_SVH
`define BOOTMEM_PARAMS_SVH

// ---------------------------------------------------------------------
// boot memory geometry
// ---------------------------------------------------------------------

`define BOOTMEM_AW     8     // word address bits, one address per data word
`define BOOTMEM_DW     32    // data bus width in bits, four byte lanes
`define BOOTMEM_DEPTH  256   // number of words held by the memory array

// ---------------------------------------------------------------------
// response slot behaviour
// ---------------------------------------------------------------------

// with the bypass set the core may take a new command in the very cycle
// its pending response is popped, so the memory sustains one command
// per cycle
// with the bypass cleared a command waits one idle cycle after each pop
`define BOOTMEM_BYPASS 1     // 1 enables the pop-and-push path, 0 disables it

// a depth of 2**BOOTMEM_AW words covers the whole address space
// a smaller depth leaves the upper addresses unbacked

`endif

// File: hdl/bootmem_pkg.sv
`include "bootmem_params.svh"

package bootmem_pkg;

   // ------------------------------------------------------------------
   // vector types shared by the memory subsystem
   // ------------------------------------------------------------------

   typedef logic [`BOOTMEM_AW-1:0]   word_addr_t;   // word address, not byte address
   typedef logic [`BOOTMEM_DW-1:0]   word_t;        // one data word of the bus
   typedef logic [`BOOTMEM_DW/8-1:0] byte_mask_t;   // bit i enables byte lane i

   // requester number as seen by the arbiter
   // 0 is the instruction fetch port and 1 is the load/store port
   typedef logic port_id_t;

   // ------------------------------------------------------------------
   // arbiter response tracking
   // ------------------------------------------------------------------

   // the memory owes at most one response at any time
   typedef enum logic {
      RSP_IDLE = 1'b0,   // no response is owed to any requester
      RSP_BUSY = 1'b1    // one response is in flight toward its owner
   } arb_state_t;

   // a zero byte mask on a command marks it as a read
   // any set bit turns it into a write of the selected lanes

endpackage

// File: hdl/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if
   import bootmem_pkg::*;
();

   // ------------------------------------------------------------------
   // command channel, master to slave
   // ------------------------------------------------------------------

   logic       cmd_valid;    // master presents a command
   logic       cmd_ready;    // slave takes the command in this cycle
   word_addr_t cmd_addr;     // word address of the access
   byte_mask_t cmd_we_msk;   // byte write mask, all zero means read
   word_t      cmd_din;      // write data, lanes picked by cmd_we_msk

   // ------------------------------------------------------------------
   // response channel, slave to master
   // ------------------------------------------------------------------

   logic       rsp_valid;    // slave holds a response for the master
   logic       rsp_ready;    // master pops the response in this cycle
   word_t      rsp_dout;     // read data, only meaningful after a read

   // requester side of the channel
   modport master (
      output cmd_valid, cmd_addr, cmd_we_msk, cmd_din,
      output rsp_ready,
      input  cmd_ready,
      input  rsp_valid, rsp_dout
   );

   // memory side of the channel
   modport slave (
      input  cmd_valid, cmd_addr, cmd_we_msk, cmd_din,
      input  rsp_ready,
      output cmd_ready,
      output rsp_valid, rsp_dout
   );

endinterface

// File: hdl/bootmem_core.sv
`timescale 1ns/1ns

`include "bootmem_params.svh"

module bootmem_core
   import bootmem_pkg::*;
#(
   parameter int DEPTH_WORDS = `BOOTMEM_DEPTH   // words in the array
)
(
   input  logic     clk,
   input  logic     rst_n,
   mem_bus_if.slave bus
);

   localparam int LANES = `BOOTMEM_DW / 8;   // byte lanes per word

   word_t mem_q [DEPTH_WORDS];   // the boot memory itself
   logic  push;                  // command accepted in this cycle
   logic  pop;                   // response popped in this cycle
   logic  rsp_valid_q;           // the single response slot is full

   // the array starts cleared, there is no preload image
   initial begin : clear_blk
      for (int i = 0; i < DEPTH_WORDS; i++) begin
         mem_q[i] = '0;
      end
   end

   assign push = bus.cmd_valid & bus.cmd_ready;   // handshake on the command side
   assign pop  = rsp_valid_q & bus.rsp_ready;     // handshake on the response side

   // ------------------------------------------------------------------
   // command acceptance
   // ------------------------------------------------------------------

   // the slot flag alone decides whether a new command fits
   if (`BOOTMEM_BYPASS != 0) begin : g_bypass
      assign bus.cmd_ready = ~rsp_valid_q | pop;   // a slot freed this cycle is reused
   end else begin : g_no_bypass
      assign bus.cmd_ready = ~rsp_valid_q;         // wait until the slot is empty
   end

   // ------------------------------------------------------------------
   // storage and read data
   // ------------------------------------------------------------------

   // byte lanes with a set mask bit take the new data, the rest keep theirs
   always @(posedge clk) begin
      if (push) begin
         for (int b = 0; b < LANES; b++) begin
            if (bus.cmd_we_msk[b]) begin
               mem_q[bus.cmd_addr][b*8 +: 8] <= bus.cmd_din[b*8 +: 8];
            end
         end
      end
   end

   // read data is registered on the acceptance edge and held until replaced
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus.rsp_dout <= '0;
      end else if (push && (bus.cmd_we_msk == '0)) begin
         bus.rsp_dout <= mem_q[bus.cmd_addr];   // a write leaves the old word here
      end
   end

   // ------------------------------------------------------------------
   // response slot
   // ------------------------------------------------------------------

   // every accepted command fills the slot, a pop empties it
   // push wins when both happen together under bypass
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid_q <= 1'b0;
      end else if (push) begin
         rsp_valid_q <= 1'b1;
      end else if (pop) begin
         rsp_valid_q <= 1'b0;
      end
   end

   assign bus.rsp_valid = rsp_valid_q;   // back-pressure simply holds the slot

endmodule

// File: hdl/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter
   import bootmem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   mem_bus_if.slave  req0,
   mem_bus_if.slave  req1,
   mem_bus_if.master mem
);

   port_id_t   rr_ptr_q;   // requester that wins the next tie
   port_id_t   grant;      // requester steered onto the memory bus now
   port_id_t   owner_q;    // requester the pending response belongs to
   arb_state_t state_q;    // whether a response is owed at all
   arb_state_t state_d;
   logic       accept;     // the memory takes the granted command
   logic       pop;        // the owner pops the pending response

   // ------------------------------------------------------------------
   // command path, purely combinational
   // ------------------------------------------------------------------

   // a lone requester wins outright, a tie goes to the pointer
   always_comb begin
      case ({req1.cmd_valid, req0.cmd_valid})
         2'b01:   grant = 1'b0;       // only the fetch port asks
         2'b10:   grant = 1'b1;       // only the load/store port asks
         default: grant = rr_ptr_q;   // both or neither
      endcase
   end

   assign mem.cmd_valid  = req0.cmd_valid | req1.cmd_valid;
   assign mem.cmd_addr   = grant ? req1.cmd_addr   : req0.cmd_addr;
   assign mem.cmd_we_msk = grant ? req1.cmd_we_msk : req0.cmd_we_msk;
   assign mem.cmd_din    = grant ? req1.cmd_din    : req0.cmd_din;

   // only the granted requester ever sees ready
   assign req0.cmd_ready = mem.cmd_ready & (grant == 1'b0);
   assign req1.cmd_ready = mem.cmd_ready & (grant == 1'b1);

   assign accept = mem.cmd_valid & mem.cmd_ready;

   // the pointer moves away from whoever was just served
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rr_ptr_q <= 1'b0;
      end else if (accept) begin
         rr_ptr_q <= ~grant;
      end
   end

   // ------------------------------------------------------------------
   // response tracking
   // ------------------------------------------------------------------

   assign pop = mem.rsp_valid & mem.rsp_ready;

   // a pop together with a new accept keeps the FSM busy for the new owner
   always_comb begin
      state_d = state_q;
      case (state_q)
         RSP_IDLE: begin
            if (accept) begin
               state_d = RSP_BUSY;
            end
         end
         RSP_BUSY: begin
            if (pop && !accept) begin
               state_d = RSP_IDLE;
            end
         end
         default: state_d = RSP_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= RSP_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // the core holds one response at most, so one owner register suffices
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner_q <= 1'b0;
      end else if (accept) begin
         owner_q <= grant;   // recorded on the same edge the command lands
      end
   end

   // ------------------------------------------------------------------
   // response routing back to the owner
   // ------------------------------------------------------------------

   assign req0.rsp_valid = mem.rsp_valid & (state_q == RSP_BUSY) & (owner_q == 1'b0);
   assign req1.rsp_valid = mem.rsp_valid & (state_q == RSP_BUSY) & (owner_q == 1'b1);

   // the other port sees zero data rather than someone else's word
   assign req0.rsp_dout = (owner_q == 1'b0) ? mem.rsp_dout : '0;
   assign req1.rsp_dout = (owner_q == 1'b1) ? mem.rsp_dout : '0;

   // the pop comes from the owner alone
   assign mem.rsp_ready = (state_q == RSP_BUSY) &
                          (owner_q ? req1.rsp_ready : req0.rsp_ready);

endmodule

// File: hdl/bootmem_top.sv
`timescale 1ns/1ns

`include "bootmem_params.svh"

module bootmem_top
   import bootmem_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,

   // ------------------------------------------------------------------
   // instruction fetch port
   // ------------------------------------------------------------------

   input  logic       fetch_cmd_valid,
   output logic       fetch_cmd_ready,
   input  word_addr_t fetch_cmd_addr,
   input  byte_mask_t fetch_cmd_we_msk,   // normally zero, fetch only reads
   input  word_t      fetch_cmd_din,
   output logic       fetch_rsp_valid,
   input  logic       fetch_rsp_ready,
   output word_t      fetch_rsp_dout,

   // ------------------------------------------------------------------
   // load/store port
   // ------------------------------------------------------------------

   input  logic       ls_cmd_valid,
   output logic       ls_cmd_ready,
   input  word_addr_t ls_cmd_addr,
   input  byte_mask_t ls_cmd_we_msk,      // store byte enables, zero for a load
   input  word_t      ls_cmd_din,
   output logic       ls_rsp_valid,
   input  logic       ls_rsp_ready,
   output word_t      ls_rsp_dout
);

   mem_bus_if req0_bus ();   // fetch port toward the arbiter
   mem_bus_if req1_bus ();   // load/store port toward the arbiter
   mem_bus_if mem_bus ();    // arbiter toward the memory core

   // ------------------------------------------------------------------
   // fetch port onto req0_bus
   // ------------------------------------------------------------------

   assign req0_bus.cmd_valid  = fetch_cmd_valid;
   assign req0_bus.cmd_addr   = fetch_cmd_addr;
   assign req0_bus.cmd_we_msk = fetch_cmd_we_msk;
   assign req0_bus.cmd_din    = fetch_cmd_din;
   assign req0_bus.rsp_ready  = fetch_rsp_ready;
   assign fetch_cmd_ready     = req0_bus.cmd_ready;
   assign fetch_rsp_valid     = req0_bus.rsp_valid;
   assign fetch_rsp_dout      = req0_bus.rsp_dout;

   // ------------------------------------------------------------------
   // load/store port onto req1_bus
   // ------------------------------------------------------------------

   assign req1_bus.cmd_valid  = ls_cmd_valid;
   assign req1_bus.cmd_addr   = ls_cmd_addr;
   assign req1_bus.cmd_we_msk = ls_cmd_we_msk;
   assign req1_bus.cmd_din    = ls_cmd_din;
   assign req1_bus.rsp_ready  = ls_rsp_ready;
   assign ls_cmd_ready        = req1_bus.cmd_ready;
   assign ls_rsp_valid        = req1_bus.rsp_valid;
   assign ls_rsp_dout         = req1_bus.rsp_dout;

   // ------------------------------------------------------------------
   // arbiter and memory
   // ------------------------------------------------------------------

   // round-robin between the ports, adds no cycle on the command path
   bus_arbiter i_arbiter (
      .clk   (clk),
      .rst_n (rst_n),
      .req0  (req0_bus.slave),
      .req1  (req1_bus.slave),
      .mem   (mem_bus.master)
   );

   // response appears one edge after the command is taken
   bootmem_core #(
      .DEPTH_WORDS (`BOOTMEM_DEPTH)
   ) i_core (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mem_bus.slave)
   );

endmodule

// File: tb/bootmem_properties.sv
`timescale 1ns/1ns

module bootmem_properties
   import bootmem_pkg::*;
(
   input logic  clk,
   input logic  rst_n,
   input logic  fetch_cmd_ready,
   input logic  ls_cmd_ready,
   input logic  fetch_rsp_valid,
   input logic  ls_rsp_valid,
   input logic  fetch_rsp_ready,
   input logic  ls_rsp_ready,
   input word_t fetch_rsp_dout,
   input word_t ls_rsp_dout
);

   // ------------------------------------------------------------------
   // arbitration
   // ------------------------------------------------------------------

   a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
      !(fetch_cmd_ready && ls_cmd_ready))
      else $error("cmd_ready high on both ports in the same cycle");

   // ------------------------------------------------------------------
   // reset and response hold
   // ------------------------------------------------------------------

   a_fetch_rst: assert property (@(posedge clk) $rose(rst_n) |-> !fetch_rsp_valid)
      else $error("fetch_rsp_valid high right after reset");

   a_ls_rst: assert property (@(posedge clk) $rose(rst_n) |-> !ls_rsp_valid)
      else $error("ls_rsp_valid high right after reset");

   // a response that is not popped stays put with its data
   a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rsp_valid && !fetch_rsp_ready |=> fetch_rsp_valid && $stable(fetch_rsp_dout))
      else $error("fetch response changed under back-pressure");

   a_ls_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ls_rsp_valid && !ls_rsp_ready |=> ls_rsp_valid && $stable(ls_rsp_dout))
      else $error("load/store response changed under back-pressure");

endmodule

bind bootmem_top bootmem_properties i_props (
   .clk (clk), .rst_n (rst_n),
   .fetch_cmd_ready (fetch_cmd_ready), .ls_cmd_ready (ls_cmd_ready),
   .fetch_rsp_valid (fetch_rsp_valid), .ls_rsp_valid (ls_rsp_valid),
   .fetch_rsp_ready (fetch_rsp_ready), .ls_rsp_ready (ls_rsp_ready),
   .fetch_rsp_dout (fetch_rsp_dout), .ls_rsp_dout (ls_rsp_dout)
);

// File: tb/tb_bootmem.sv
`timescale 1ns/1ns

`include "bootmem_params.svh"

module tb_bootmem
   import bootmem_pkg::*;
();

   // ------------------------------------------------------------------
   // test lengths and run limit
   // ------------------------------------------------------------------

   localparam int N_BLANK    = 8;     // reads of never written words on both ports
   localparam int N_FULL     = 24;    // full-mask writes and the cross-port reads
   localparam int N_MERGE    = 60;    // byte lane merges plus the fetch read-back
   localparam int N_STREAM   = 64;    // back-to-back traffic on both ports
   localparam int N_BPRESS   = 80;    // back-to-back traffic with random rsp_ready
   localparam int N_MIXED    = 400;   // random traffic with gaps
   localparam int TOTAL_CMDS = N_BLANK + N_FULL + N_MERGE + N_STREAM + N_BPRESS + N_MIXED;
   localparam int WATCHDOG_NS = (TOTAL_CMDS * 20 + 16) * 8;   // 20 cycles of 8 ns per command

   logic        clk;
   logic        rst_n;
   logic [1:0]  cmd_valid;          // bit 0 is the fetch port, bit 1 the load/store port
   logic [1:0]  cmd_ready;
   word_addr_t  cmd_addr [2];
   byte_mask_t  cmd_we_msk [2];
   word_t       cmd_din [2];
   logic [1:0]  rsp_valid;
   logic [1:0]  rsp_ready;
   word_t       fetch_rsp_dout;
   word_t       ls_rsp_dout;
   logic        bp_on;              // random back-pressure on both response channels
   int          seed = 24791;
   word_t       model [`BOOTMEM_DEPTH];   // reference copy of the boot memory
   logic [32:0] exp_fetch [$];      // bit 32 marks a read, the low bits hold its word
   logic [32:0] exp_ls [$];
   port_id_t    last_port;          // port of the most recently accepted command

   bootmem_top i_dut (
      .clk              (clk),
      .rst_n            (rst_n),
      .fetch_cmd_valid  (cmd_valid[0]),
      .fetch_cmd_ready  (cmd_ready[0]),
      .fetch_cmd_addr   (cmd_addr[0]),
      .fetch_cmd_we_msk (cmd_we_msk[0]),
      .fetch_cmd_din    (cmd_din[0]),
      .fetch_rsp_valid  (rsp_valid[0]),
      .fetch_rsp_ready  (rsp_ready[0]),
      .fetch_rsp_dout   (fetch_rsp_dout),
      .ls_cmd_valid     (cmd_valid[1]),
      .ls_cmd_ready     (cmd_ready[1]),
      .ls_cmd_addr      (cmd_addr[1]),
      .ls_cmd_we_msk    (cmd_we_msk[1]),
      .ls_cmd_din       (cmd_din[1]),
      .ls_rsp_valid     (rsp_valid[1]),
      .ls_rsp_ready     (rsp_ready[1]),
      .ls_rsp_dout      (ls_rsp_dout)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // ------------------------------------------------------------------
   // reference model and error reporting
   // ------------------------------------------------------------------

   // returns the word as it was before the access, which is the read result
   function automatic word_t ref_access(word_addr_t addr, byte_mask_t msk, word_t din);
      word_t old;
      old = model[addr];
      for (int b = 0; b < 4; b++) begin
         if (msk[b]) model[addr][b*8 +: 8] = din[b*8 +: 8];   // set lanes take the new byte
      end
      return old;
   endfunction

   task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "wrong value on %s", name);
   endtask

   task automatic report_failure(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      $display("FAIL: see errors above");
      $fatal(1, "%s", what);
   endtask

   // ------------------------------------------------------------------
   // drivers, inputs change on the falling edge only
   // ------------------------------------------------------------------

   // holds the command until the port sees ready, then books the expected response
   task automatic issue(input port_id_t p, input word_addr_t a, input byte_mask_t m, input word_t d);
      @(negedge clk);
      cmd_valid[p]  = 1'b1;
      cmd_addr[p]   = a;
      cmd_we_msk[p] = m;
      cmd_din[p]    = d;
      do @(posedge clk); while (!cmd_ready[p]);   // the watchdog covers a stuck port
      if (p == 1'b0) exp_fetch.push_back({m == '0, ref_access(a, m, d)});
      else exp_ls.push_back({m == '0, ref_access(a, m, d)});
   endtask

   task automatic gap(input port_id_t p, input int n);
      repeat (n) begin
         @(negedge clk);
         cmd_valid[p] = 1'b0;   // idle cycle on this port
      end
   endtask

   // waits until every booked response has come back
   task automatic drain();
      @(negedge clk);
      cmd_valid = 2'b00;
      while (exp_fetch.size() != 0 || exp_ls.size() != 0) @(posedge clk);
   endtask

   task automatic write_block(input port_id_t p, input word_addr_t base, input int n);
      for (int i = 0; i < n; i++) begin
         issue(p, word_addr_t'(base + i), 4'hF, word_t'($random(seed)));
      end
      gap(p, 1);   // the port goes idle while the other one may still be busy
   endtask

   task automatic read_block(input port_id_t p, input word_addr_t base, input int n);
      for (int i = 0; i < n; i++) begin
         issue(p, word_addr_t'(base + i), '0, '0);
      end
      gap(p, 1);   // the port goes idle while the other one may still be busy
   endtask

   // each of the 15 nonzero masks lands on a fresh word over a known pattern
   task automatic merge_bytes();
      word_addr_t a;
      for (int m = 1; m < 16; m++) begin
         a = word_addr_t'(8'h40 + m);
         issue(1'b1, a, 4'hF, 32'hA5A5_5A5A);
         issue(1'b1, a, byte_mask_t'(m), word_t'($random(seed)));
         issue(1'b1, a, '0, '0);   // read back the merged word
      end
   endtask

   task automatic random_traffic(input port_id_t p, input int n, input int max_gap);
      word_addr_t a;
      byte_mask_t m;
      for (int i = 0; i < n; i++) begin
         a = word_addr_t'($random(seed));
         m = ($random(seed) % 2 == 0) ? '0 : byte_mask_t'($random(seed));   // about half reads
         issue(p, a, m, word_t'($random(seed)));
         if (max_gap > 0) gap(p, {$random(seed)} % (max_gap + 1));
      end
      gap(p, 1);   // the port goes idle while the other one may still be busy
   endtask

   task automatic bp_loop();
      forever begin
         @(negedge clk);
         rsp_ready = bp_on ? 2'($random(seed)) : 2'b11;   // both ready unless back-pressure
      end
   endtask

   // ------------------------------------------------------------------
   // comparers, one per port, sampled on the rising edge
   // ------------------------------------------------------------------

   task automatic check_response(input port_id_t p, inout logic acc_prev);
      logic [32:0] e;
      word_t       got;
      if (acc_prev) begin
         assert (rsp_valid[p])
            else report_failure("response not valid one cycle after accept");
      end
      if (rsp_valid[p] && rsp_ready[p]) begin
         if (p == 1'b0) begin
            assert (exp_fetch.size() != 0)
               else report_failure("fetch port got a response it never asked for");
            e = exp_fetch.pop_front();
         end else begin
            assert (exp_ls.size() != 0)
               else report_failure("load/store port got a response it never asked for");
            e = exp_ls.pop_front();
         end
         got = p ? ls_rsp_dout : fetch_rsp_dout;
         if (e[32]) begin
            assert (got == e[31:0])
               else report_mismatch(p ? "ls_rsp_dout" : "fetch_rsp_dout", e[31:0], got);
         end
      end
      acc_prev = cmd_valid[p] & cmd_ready[p];   // next edge must show the response
   endtask

   always @(posedge clk) begin : cmp_fetch
      logic acc_prev;
      if (!rst_n) acc_prev = 1'b0;
      else check_response(1'b0, acc_prev);
   end

   always @(posedge clk) begin : cmp_ls
      logic acc_prev;
      if (!rst_n) acc_prev = 1'b0;
      else check_response(1'b1, acc_prev);
   end

   // with both ports waiting the grant must move away from the last winner
   always @(posedge clk) begin : arb_check
      if (!rst_n) begin
         last_port = 1'b1;   // pointer starts on the fetch port
      end else if ((cmd_valid & cmd_ready) != 2'b00) begin
         if (cmd_valid == 2'b11) begin
            assert (!cmd_ready[last_port])
               else report_failure("same port granted twice while both waited");
         end
         last_port = port_id_t'(cmd_valid[1] & cmd_ready[1]);
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: the commands did not all complete in the allowed time");
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------

   initial begin : main
      rst_n = 1'b0;
      cmd_valid = 2'b00;
      rsp_ready = 2'b11;
      bp_on = 1'b0;
      for (int i = 0; i < 2; i++) begin
         cmd_addr[i] = '0;
         cmd_we_msk[i] = '0;
         cmd_din[i] = '0;
      end
      for (int i = 0; i < `BOOTMEM_DEPTH; i++) model[i] = '0;   // memory starts cleared
      fork
         bp_loop();
      join_none
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (!rsp_valid[0]) else report_mismatch("fetch_rsp_valid", '0, word_t'(rsp_valid[0]));
      assert (!rsp_valid[1]) else report_mismatch("ls_rsp_valid", '0, word_t'(rsp_valid[1]));
      fork
         read_block(1'b0, 8'hF0, 4);   // never written
         read_block(1'b1, 8'hE0, 4);
      join
      drain();
      fork
         write_block(1'b1, 8'h10, 8);
         write_block(1'b0, 8'h20, 4);
      join
      drain();
      fork
         read_block(1'b0, 8'h10, 8);   // crossed over
         read_block(1'b1, 8'h20, 4);
      join
      drain();
      merge_bytes();
      drain();
      read_block(1'b0, 8'h41, 15);   // merged words seen from the other port
      drain();
      fork
         random_traffic(1'b0, 32, 0);
         random_traffic(1'b1, 32, 0);
      join
      drain();
      bp_on = 1'b1;
      fork
         random_traffic(1'b0, 40, 0);
         random_traffic(1'b1, 40, 0);
      join
      drain();
      fork
         random_traffic(1'b0, 200, 3);
         random_traffic(1'b1, 200, 3);
      join
      drain();
      $display("PASS: all tests");
      $finish;
   end

endmodule

// File: list.f
+incdir+hdl
hdl/bootmem_pkg.sv
hdl/mem_bus_if.sv
hdl/bootmem_core.sv
hdl/bus_arbiter.sv
hdl/bootmem_top.sv
tb/bootmem_properties.sv
tb/tb_bootmem.sv

// File: Makefile
# Verilator build of the boot memory testbench
# the run target fails when the simulation ends with $fatal

TOP := tb_bootmem

.PHONY: all compile run clean

all: run

# elaborates the RTL, the bound properties and the testbench
compile:
	verilator --binary --timing --assert \
		-f list.f \
		--top-module $(TOP) \
		-o V$(TOP)

# the exit status of the simulation is the result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
